// File: Makefile
VERILATOR  ?= verilator
TOP        := wb_subsystem_tb
RTL_TOP    := wb_subsystem_top
FILELIST   := project.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing --assert --timescale 1ns/100ps
LINT_FLAGS := --lint-only --timing --assert --timescale 1ns/100ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: include/wb_config.svh
// bus widths, slave address map, ram and mailbox depths, master bus timeout
`ifndef WB_CONFIG_SVH
`define WB_CONFIG_SVH

// wishbone bus widths
`define WB_ADR_W 32
`define WB_DAT_W 32
`define WB_SEL_W 4

// slave id is the top address byte
`define WB_ID_W 8

// address map, compared against adr[31:24]
`define WB_SLAVE_RAM  8'h00
`define WB_SLAVE_MBOX 8'h01

// scratch ram depth in 32-bit words
`define WB_RAM_WORDS 64

// mailbox fifo depth in words
`define WB_MBOX_DEPTH 4

// cycles without ack before the master aborts
`define WB_TIMEOUT_CYCLES 15

`endif

// File: project.f
+incdir+include
verilog/wb_pkg.sv
verilog/wb_host_master.sv
verilog/wishbone_interconnect.sv
verilog/wb_scratch_ram.sv
verilog/wb_mailbox.sv
verilog/wb_subsystem_top.sv
test/wb_subsystem_properties.sv
test/wb_subsystem_tb.sv

// File: test/wb_subsystem_properties.sv
// wishbone protocol assertions on the interconnect, attached by bind
`timescale 1ns/100ps

module wb_subsystem_properties (
    input logic clk_i,
    input logic rst_i,
    input logic m_cyc_i,
    input logic m_stb_i,
    input logic m_ack_o,
    input logic s0_stb_o,
    input logic s1_stb_o,
    input logic s0_ack_i,
    input logic s1_ack_i
);

    // strobe only inside a cycle
    stb_needs_cyc: assert property (@(posedge clk_i) disable iff (rst_i) m_stb_i |-> m_cyc_i)
        else $error("master stb high without cyc");

    // decoder never strobes both slaves
    one_slave: assert property (@(posedge clk_i) disable iff (rst_i) !(s0_stb_o && s1_stb_o))
        else $error("both slaves strobed at once");

    // acks only answer a live strobe
    ack_in_stb: assert property (@(posedge clk_i) disable iff (rst_i) m_ack_o |-> m_stb_i)
        else $error("master ack without stb");
    ram_ack_in_stb: assert property (@(posedge clk_i) disable iff (rst_i) s0_ack_i |-> s0_stb_o)
        else $error("ram ack without its stb");
    mbox_ack_in_stb: assert property (@(posedge clk_i) disable iff (rst_i) s1_ack_i |-> s1_stb_o)
        else $error("mailbox ack without its stb");

    // single-cycle ack
    ack_one_cycle: assert property (@(posedge clk_i) disable iff (rst_i) m_ack_o |=> !m_ack_o)
        else $error("master ack high two cycles in a row");

endmodule

// File: test/wb_subsystem_tb.sv
// testbench for the wishbone subsystem: clock, reset, data-file driven requests and checks
`timescale 1ns/100ps
`include "wb_config.svh"

module wb_subsystem_tb
    import wb_pkg::*;
();

    // cycles allowed for any single wait
    localparam int WAIT_LIMIT     = 40;
    // request edge to done edge on a mapped slave
    localparam int MAPPED_LATENCY = 2;

    logic    clk_i;
    logic    rst_i;
    logic    req_i;
    logic    we_i;
    wb_adr_t adr_i;
    wb_dat_t wdat_i;
    wb_sel_t sel_i;
    logic    busy_o;
    logic    done_o;
    logic    err_o;
    wb_dat_t rdat_o;
    logic    int_o;

    // data file line being run, for error lines
    int      data_line;

    wb_subsystem_top i_wb_subsystem_top (
        .clk_i(clk_i), .rst_i(rst_i),
        .req_i(req_i), .we_i(we_i), .adr_i(adr_i), .wdat_i(wdat_i), .sel_i(sel_i),
        .busy_o(busy_o), .done_o(done_o), .err_o(err_o), .rdat_o(rdat_o), .int_o(int_o)
    );

    // protocol checks on the router
    bind wishbone_interconnect wb_subsystem_properties i_wb_subsystem_properties (
        .clk_i(clk_i), .rst_i(rst_i), .m_cyc_i(m_cyc_i), .m_stb_i(m_stb_i),
        .m_ack_o(m_ack_o), .s0_stb_o(s0_stb_o), .s1_stb_o(s1_stb_o),
        .s0_ack_i(s0_ack_i), .s1_ack_i(s1_ack_i)
    );

    // 100 ns clock
    initial begin
        clk_i = 1'b0;
        forever begin
            #50 clk_i = ~clk_i;
        end
    end

    task automatic fail_run(input string why);
        $display(">>> FAIL");
        $fatal(1, "%s", why);
    endtask

    task automatic check_value(input string name, input wb_dat_t got, input wb_dat_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%08h, expected 0x%08h (data line %0d)",
                     name, got, exp, data_line);
            fail_run({"wrong value on ", name});
        end
    endtask

    // master must be idle before a new request is honored
    task automatic wait_idle();
        int n;
        n = 0;
        while (busy_o) begin
            @(negedge clk_i);
            n++;
            if (n > WAIT_LIMIT) begin
                fail_run("master stayed busy, no new request could be issued");
            end
        end
    endtask

    // one-cycle request pulse from a falling edge, then wait for done
    task automatic run_request(
        input  logic    we,
        input  wb_adr_t adr,
        input  wb_dat_t wdat,
        input  wb_sel_t sel,
        output int      latency
    );
        int n;
        req_i  = 1'b1;
        we_i   = we;
        adr_i  = adr;
        wdat_i = wdat;
        sel_i  = sel;
        n      = 0;
        do begin
            @(negedge clk_i);
            req_i = 1'b0;
            n++;
            if (n > WAIT_LIMIT) begin
                fail_run("no done pulse from the master within 40 cycles");
            end
        end while (!done_o);
        // first falling edge follows the request edge itself
        latency = n - 1;
    endtask

    initial begin
        int      fd;
        int      code;
        int      nreq;
        int      lat;
        int      exp_lat;
        string   line;
        wb_dat_t f_we;
        wb_dat_t f_adr;
        wb_dat_t f_wdat;
        wb_dat_t f_sel;
        wb_dat_t f_rdat;
        wb_dat_t f_err;
        wb_dat_t f_int;

        rst_i     = 1'b1;
        req_i     = 1'b0;
        we_i      = 1'b0;
        adr_i     = '0;
        wdat_i    = '0;
        sel_i     = '0;
        data_line = 0;
        nreq      = 0;

        fd = $fopen("test/wb_subsystem_testdata.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open test/wb_subsystem_testdata.txt");
        end

        // reset for 3 cycles, released on a falling edge
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;

        // quiet bus and empty mailbox out of reset
        check_value("busy_o", 32'(busy_o), 32'h0);
        check_value("done_o", 32'(done_o), 32'h0);
        check_value("err_o", 32'(err_o), 32'h0);
        check_value("int_o", 32'(int_o), 32'h0);

        while ($fgets(line, fd) != 0) begin
            data_line++;
            // blank and comment lines
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            code = $sscanf(line, "%h %h %h %h %h %h %h",
                           f_we, f_adr, f_wdat, f_sel, f_rdat, f_err, f_int);
            if (code != 7) begin
                fail_run($sformatf("malformed test data on line %0d", data_line));
            end
            wait_idle();
            run_request(f_we[0], f_adr, f_wdat, f_sel[3:0], lat);
            // unmapped ids end on the master timeout
            exp_lat = f_err[0] ? `WB_TIMEOUT_CYCLES + 1 : MAPPED_LATENCY;
            check_value("rdat_o", rdat_o, f_rdat);
            check_value("err_o", 32'(err_o), f_err);
            check_value("int_o", 32'(int_o), f_int);
            check_value("done latency", 32'(lat), 32'(exp_lat));
            nreq++;
        end
        $fclose(fd);

        if (nreq == 0) begin
            fail_run("test data file held no requests");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

// File: test/wb_subsystem_testdata.txt
# columns, all hex: we adr wdat sel exp_rdat exp_err exp_int
# we 1 writes and 0 reads; exp values are sampled with done_o
1 00000010 cafef00d f 00000000 0 0
0 00000010 00000000 f cafef00d 0 0
1 00000010 11223344 5 00000000 0 0
0 00000010 00000000 f ca22f044 0 0
1 00000024 01234567 f 00000000 0 0
1 00000024 aabbccdd 8 00000000 0 0
0 00000024 00000000 f aa234567 0 0
1 00000024 99885a5a 3 00000000 0 0
0 00000024 00000000 f aa235a5a 0 0
1 01000000 00000101 f 00000000 0 1
1 01000000 00000202 f 00000000 0 1
1 01000000 00000303 f 00000000 0 1
0 01000004 00000000 f 00000003 0 1
0 01000000 00000000 f 00000101 0 1
0 01000000 00000000 f 00000202 0 1
0 01000000 00000000 f 00000303 0 0
0 01000000 00000000 f 00000000 0 0
1 01000000 000000a1 f 00000000 0 1
1 01000000 000000a2 f 00000000 0 1
1 01000000 000000a3 f 00000000 0 1
1 01000000 000000a4 f 00000000 0 1
1 01000000 000000a5 f 00000000 0 1
0 01000004 00000000 f 00000104 0 1
0 01000004 00000000 f 00000004 0 1
0 01000000 00000000 f 000000a1 0 1
0 01000000 00000000 f 000000a2 0 1
0 01000000 00000000 f 000000a3 0 1
0 01000000 00000000 f 000000a4 0 0
0 02000010 00000000 f 00000000 1 0
1 02000010 deadbeef f 00000000 1 0
0 00000010 00000000 f ca22f044 0 0
0 00000024 00000000 f aa235a5a 0 0

// File: verilog/wb_host_master.sv
// host strobe to classic wishbone cycle master with ack timeout and error flag
`timescale 1ns/100ps
`include "wb_config.svh"

module wb_host_master
    import wb_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_i,

    // host request side
    input  logic    req_i,
    input  logic    we_i,
    input  wb_adr_t adr_i,
    input  wb_dat_t wdat_i,
    input  wb_sel_t sel_i,
    output logic    busy_o,
    output logic    done_o,
    output logic    err_o,
    output wb_dat_t rdat_o,

    // wishbone master side
    output logic    m_cyc_o,
    output logic    m_stb_o,
    output logic    m_we_o,
    output wb_sel_t m_sel_o,
    output wb_adr_t m_adr_o,
    output wb_dat_t m_dat_o,
    input  wb_dat_t m_dat_i,
    input  logic    m_ack_i
);

    // wide enough to hold the full timeout count
    localparam int TMO_W = $clog2(`WB_TIMEOUT_CYCLES + 1);

    master_state_t    state;
    logic [TMO_W-1:0] tmo_cnt;
    logic             accept;
    logic             timeout;

    // requests only taken while idle, others are dropped
    assign accept  = req_i && (state == st_idle);
    // counter ran out with no ack
    assign timeout = (state == st_bus) && !m_ack_i && (tmo_cnt == '0);

    // fsm, strobes and timeout counter
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state   <= st_idle;
            m_cyc_o <= 1'b0;
            m_stb_o <= 1'b0;
            err_o   <= 1'b0;
            tmo_cnt <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (accept) begin
                        state   <= st_bus;
                        // cyc and stb rise together
                        m_cyc_o <= 1'b1;
                        m_stb_o <= 1'b1;
                        err_o   <= 1'b0;
                        tmo_cnt <= TMO_W'(`WB_TIMEOUT_CYCLES);
                    end
                end
                st_bus: begin
                    if (m_ack_i || timeout) begin
                        state   <= st_done;
                        // and fall together
                        m_cyc_o <= 1'b0;
                        m_stb_o <= 1'b0;
                        err_o   <= timeout;
                    end else begin
                        tmo_cnt <= tmo_cnt - 1'b1;
                    end
                end
                st_done: begin
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // latched request and returned data
    always_ff @(posedge clk_i) begin
        if (accept) begin
            m_we_o  <= we_i;
            m_adr_o <= adr_i;
            m_dat_o <= wdat_i;
            m_sel_o <= sel_i;
        end
        // read data sampled with ack, zero for writes and aborts
        if (m_ack_i && (state == st_bus)) begin
            rdat_o <= m_we_o ? '0 : m_dat_i;
        end else if (timeout) begin
            rdat_o <= '0;
        end
    end

    // busy through the done cycle
    assign busy_o = (state != st_idle);
    assign done_o = (state == st_done);

endmodule

// File: verilog/wb_mailbox.sv
// wishbone mailbox slave: fifo data port, status register, not-empty interrupt
`timescale 1ns/100ps
`include "wb_config.svh"

module wb_mailbox
    import wb_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_i,
    input  logic    cyc_i,
    input  logic    stb_i,
    input  logic    we_i,
    input  wb_adr_t adr_i,
    input  wb_dat_t dat_i,
    output wb_dat_t dat_o,
    output logic    ack_o,
    output logic    int_o
);

    localparam int PTR_W = $clog2(`WB_MBOX_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    wb_dat_t          fifo [`WB_MBOX_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             ovf;
    logic             take;
    logic             sel_data;
    logic             sel_stat;
    logic             full;
    logic             empty;

    assign take     = cyc_i && stb_i && !ack_o;
    // word offset 0 data, 1 status
    assign sel_data = (adr_i[3:2] == 2'd0);
    assign sel_stat = (adr_i[3:2] == 2'd1);
    assign full     = (count == CNT_W'(`WB_MBOX_DEPTH));
    assign empty    = (count == '0);

    // pointers, count, overflow flag and ack
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            ovf    <= 1'b0;
            ack_o  <= 1'b0;
        end else begin
            ack_o <= take;
            if (take && sel_data && we_i) begin
                // push, or drop and flag when full
                if (full) begin
                    ovf <= 1'b1;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                    count  <= count + 1'b1;
                end
            end else if (take && sel_data && !empty) begin
                // pop
                rd_ptr <= rd_ptr + 1'b1;
                count  <= count - 1'b1;
            end else if (take && sel_stat && !we_i) begin
                // status read clears sticky overflow
                ovf <= 1'b0;
            end
        end
    end

    // fifo storage and read data
    always_ff @(posedge clk_i) begin
        if (take && sel_data && we_i && !full) begin
            fifo[wr_ptr] <= dat_i;
        end
        if (take && !we_i) begin
            if (sel_data) begin
                dat_o <= empty ? '0 : fifo[rd_ptr];
            end else if (sel_stat) begin
                // count in 2..0, overflow in 8
                dat_o <= {{(`WB_DAT_W-9){1'b0}}, ovf, {(8-CNT_W){1'b0}}, count};
            end else begin
                dat_o <= '0;
            end
        end
    end

    // follows count, so moves on the push or pop edge
    assign int_o = !empty;

endmodule

// File: verilog/wb_pkg.sv
// wishbone bus vector typedefs and the host master state enum
`include "wb_config.svh"

package wb_pkg;

    // byte address on the bus
    typedef logic [`WB_ADR_W-1:0] wb_adr_t;

    // one data word
    typedef logic [`WB_DAT_W-1:0] wb_dat_t;

    // one select bit per byte lane
    typedef logic [`WB_SEL_W-1:0] wb_sel_t;

    // decoded top address byte
    typedef logic [`WB_ID_W-1:0] wb_slave_id_t;

    // host master fsm
    // idle waits for a request, bus holds the cycle open, done is the completion pulse
    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_bus  = 2'd1,
        st_done = 2'd2
    } master_state_t;

endpackage

// File: verilog/wb_scratch_ram.sv
// wishbone scratch ram slave with byte-lane writes and registered ack
`timescale 1ns/100ps
`include "wb_config.svh"

module wb_scratch_ram
    import wb_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_i,
    input  logic    cyc_i,
    input  logic    stb_i,
    input  logic    we_i,
    input  wb_sel_t sel_i,
    input  wb_adr_t adr_i,
    input  wb_dat_t dat_i,
    output wb_dat_t dat_o,
    output logic    ack_o
);

    localparam int IDX_W = $clog2(`WB_RAM_WORDS);

    wb_dat_t          mem [`WB_RAM_WORDS];
    logic [IDX_W-1:0] idx;
    logic             take;

    // word index, byte offset bits dropped
    assign idx  = adr_i[IDX_W+1:2];
    // new access, not the one already acked
    assign take = cyc_i && stb_i && !ack_o;

    // single-cycle ack
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= take;
        end
    end

    // storage and read port
    always_ff @(posedge clk_i) begin
        if (take) begin
            if (we_i) begin
                // only selected lanes change
                for (int b = 0; b < `WB_SEL_W; b++) begin
                    if (sel_i[b]) begin
                        mem[idx][8*b +: 8] <= dat_i[8*b +: 8];
                    end
                end
            end else begin
                dat_o <= mem[idx];
            end
        end
    end

endmodule

// File: verilog/wb_subsystem_top.sv
// top level wiring the host master, interconnect, scratch ram and mailbox slaves
`timescale 1ns/100ps

module wb_subsystem_top
    import wb_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_i,
    input  logic    req_i,
    input  logic    we_i,
    input  wb_adr_t adr_i,
    input  wb_dat_t wdat_i,
    input  wb_sel_t sel_i,
    output logic    busy_o,
    output logic    done_o,
    output logic    err_o,
    output wb_dat_t rdat_o,
    output logic    int_o
);

    // master side of the interconnect
    logic    m_cyc;
    logic    m_stb;
    logic    m_we;
    wb_sel_t m_sel;
    wb_adr_t m_adr;
    wb_dat_t m_wdat;
    wb_dat_t m_rdat;
    logic    m_ack;

    // ram port
    logic    s0_we;
    logic    s0_cyc;
    logic    s0_stb;
    wb_sel_t s0_sel;
    wb_adr_t s0_adr;
    wb_dat_t s0_wdat;
    wb_dat_t s0_rdat;
    logic    s0_ack;

    // mailbox port
    logic    s1_we;
    logic    s1_cyc;
    logic    s1_stb;
    wb_adr_t s1_adr;
    wb_dat_t s1_wdat;
    wb_dat_t s1_rdat;
    logic    s1_ack;
    logic    s1_int;

    wb_host_master i_wb_host_master (
        .clk_i(clk_i), .rst_i(rst_i),
        .req_i(req_i), .we_i(we_i), .adr_i(adr_i), .wdat_i(wdat_i), .sel_i(sel_i),
        .busy_o(busy_o), .done_o(done_o), .err_o(err_o), .rdat_o(rdat_o),
        .m_cyc_o(m_cyc), .m_stb_o(m_stb), .m_we_o(m_we), .m_sel_o(m_sel),
        .m_adr_o(m_adr), .m_dat_o(m_wdat), .m_dat_i(m_rdat), .m_ack_i(m_ack)
    );

    // mailbox takes whole words only
    wishbone_interconnect i_wishbone_interconnect (
        .clk_i(clk_i), .rst_i(rst_i),
        .m_we_i(m_we), .m_cyc_i(m_cyc), .m_stb_i(m_stb), .m_sel_i(m_sel),
        .m_adr_i(m_adr), .m_dat_i(m_wdat),
        .m_dat_o(m_rdat), .m_ack_o(m_ack), .m_int_o(int_o),
        .s0_we_o(s0_we), .s0_cyc_o(s0_cyc), .s0_stb_o(s0_stb), .s0_sel_o(s0_sel),
        .s0_adr_o(s0_adr), .s0_dat_o(s0_wdat), .s0_dat_i(s0_rdat), .s0_ack_i(s0_ack),
        .s1_we_o(s1_we), .s1_cyc_o(s1_cyc), .s1_stb_o(s1_stb), .s1_sel_o(),
        .s1_adr_o(s1_adr), .s1_dat_o(s1_wdat), .s1_dat_i(s1_rdat), .s1_ack_i(s1_ack),
        .s1_int_i(s1_int)
    );

    wb_scratch_ram i_wb_scratch_ram (
        .clk_i(clk_i), .rst_i(rst_i),
        .cyc_i(s0_cyc), .stb_i(s0_stb), .we_i(s0_we), .sel_i(s0_sel),
        .adr_i(s0_adr), .dat_i(s0_wdat), .dat_o(s0_rdat), .ack_o(s0_ack)
    );

    wb_mailbox i_wb_mailbox (
        .clk_i(clk_i), .rst_i(rst_i),
        .cyc_i(s1_cyc), .stb_i(s1_stb), .we_i(s1_we),
        .adr_i(s1_adr), .dat_i(s1_wdat), .dat_o(s1_rdat), .ack_o(s1_ack),
        .int_o(s1_int)
    );

endmodule

// File: verilog/wishbone_interconnect.sv
// one master to two slave wishbone router with top-byte address decode
`timescale 1ns/100ps
`include "wb_config.svh"

module wishbone_interconnect
    import wb_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_i,

    // from the master
    input  logic    m_we_i,
    input  logic    m_cyc_i,
    input  logic    m_stb_i,
    input  wb_sel_t m_sel_i,
    input  wb_adr_t m_adr_i,
    input  wb_dat_t m_dat_i,
    output wb_dat_t m_dat_o,
    output logic    m_ack_o,
    output logic    m_int_o,

    // slave 0, scratch ram
    output logic    s0_we_o,
    output logic    s0_cyc_o,
    output logic    s0_stb_o,
    output wb_sel_t s0_sel_o,
    output wb_adr_t s0_adr_o,
    output wb_dat_t s0_dat_o,
    input  wb_dat_t s0_dat_i,
    input  logic    s0_ack_i,

    // slave 1, mailbox
    output logic    s1_we_o,
    output logic    s1_cyc_o,
    output logic    s1_stb_o,
    output wb_sel_t s1_sel_o,
    output wb_adr_t s1_adr_o,
    output wb_dat_t s1_dat_o,
    input  wb_dat_t s1_dat_i,
    input  logic    s1_ack_i,
    input  logic    s1_int_i
);

    wb_slave_id_t slave_id;
    wb_adr_t      local_adr;
    logic         hit0;
    logic         hit1;

    // top byte picks the slave
    assign slave_id  = m_adr_i[`WB_ADR_W-1 -: `WB_ID_W];
    assign hit0      = (slave_id == `WB_SLAVE_RAM);
    assign hit1      = (slave_id == `WB_SLAVE_MBOX);
    // slaves see the address with the id byte cleared
    assign local_adr = {{`WB_ID_W{1'b0}}, m_adr_i[`WB_ADR_W-`WB_ID_W-1:0]};

    // request signals gated to the addressed slave only
    assign s0_we_o  = hit0 ? m_we_i    : 1'b0;
    assign s0_cyc_o = hit0 ? m_cyc_i   : 1'b0;
    assign s0_stb_o = hit0 ? m_stb_i   : 1'b0;
    assign s0_sel_o = hit0 ? m_sel_i   : '0;
    assign s0_adr_o = hit0 ? local_adr : '0;
    assign s0_dat_o = hit0 ? m_dat_i   : '0;

    assign s1_we_o  = hit1 ? m_we_i    : 1'b0;
    assign s1_cyc_o = hit1 ? m_cyc_i   : 1'b0;
    assign s1_stb_o = hit1 ? m_stb_i   : 1'b0;
    assign s1_sel_o = hit1 ? m_sel_i   : '0;
    assign s1_adr_o = hit1 ? local_adr : '0;
    assign s1_dat_o = hit1 ? m_dat_i   : '0;

    // return path, unmapped ids read as zero with no ack
    always_comb begin
        m_dat_o = '0;
        m_ack_o = 1'b0;
        if (hit0) begin
            m_dat_o = s0_dat_i;
            m_ack_o = s0_ack_i;
        end else if (hit1) begin
            m_dat_o = s1_dat_i;
            m_ack_o = s1_ack_i;
        end
    end

    // mailbox is the only interrupt source
    assign m_int_o = s1_int_i;

endmodule
